// ==== common/xlate_pkg.sv ====
// ------------------------------------------------
// Widths, payload structs and the controller state
// type shared by the translation RTL and its bench
// ------------------------------------------------
package xlate_pkg;

    localparam int VADDR_BITS = 48;
    localparam int PADDR_BITS = 40;
    localparam int LEN_BITS   = 28;
    localparam int PID_BITS   = 6;
    localparam int HPID_BITS  = 16;
    localparam int DEST_BITS  = 4;

    typedef logic [VADDR_BITS-1:0] vaddr_t;
    typedef logic [PADDR_BITS-1:0] paddr_t;
    typedef logic [LEN_BITS-1:0]   len_t;
    typedef logic [PID_BITS-1:0]   pid_t;
    typedef logic [HPID_BITS-1:0]  hpid_t;
    typedef logic [DEST_BITS-1:0]  dest_t;

    // ------------------------------------------------
    // Interface payloads
    // ------------------------------------------------
    typedef struct packed {
        vaddr_t vaddr;
        len_t   len;
        pid_t   pid;
        dest_t  dest;
        logic   last;
    } req_t;

    typedef struct packed {
        vaddr_t vaddr;
        pid_t   pid;
    } tlb_lup_t;

    // ppn is a page number, shifted up by the page size on use
    typedef struct packed {
        logic   hit;
        paddr_t ppn;
        hpid_t  hpid;
    } tlb_rsp_t;

    typedef struct packed {
        paddr_t paddr;
        len_t   len;
        logic   last;
    } dma_req_t;

    typedef struct packed {
        vaddr_t vaddr;
        len_t   len;
        pid_t   pid;
    } pfault_t;

    typedef struct packed {
        vaddr_t vaddr;
        len_t   len;
        hpid_t  hpid;
        logic   last;
    } inv_t;

    typedef struct packed {
        pid_t  pid;
        dest_t dest;
    } done_t;

    // One outstanding DMA piece
    typedef struct packed {
        vaddr_t vaddr;
        len_t   len;
        hpid_t  hpid;
        pid_t   pid;
        dest_t  dest;
        logic   last;
    } entry_t;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_LUP,
        ST_WAIT_1,
        ST_WAIT_2,
        ST_CHECK,
        ST_LATCH,
        ST_CALC,
        ST_SEND,
        ST_MISS_SEND,
        ST_MISS_IDLE,
        ST_INV_WAIT
    } fsm_state_t;

endpackage

// ==== inflight/inflight_tracker.sv ====
// ------------------------------------------------
// Ring of outstanding DMA pieces. Pushed on issue,
// retired in order by dma_done, completions on last
// ------------------------------------------------
module inflight_tracker
    import xlate_pkg::*;
#(
    parameter int N_INFLIGHT_BITS = 3
) (
    input  logic                       aclk,
    input  logic                       aresetn,
    input  logic                       push,
    input  entry_t                     push_entry,
    output logic                       full,
    input  logic                       dma_done,
    output logic                       m_done_valid,
    output done_t                      m_done,
    input  logic [N_INFLIGHT_BITS-1:0] rd_ptr,
    output entry_t                     rd_entry,
    output logic [N_INFLIGHT_BITS-1:0] head,
    output logic [N_INFLIGHT_BITS-1:0] tail,
    output logic                       empty
);

    localparam int DEPTH = 1 << N_INFLIGHT_BITS;

    // Piece ring, read by the invalidation scan
    entry_t ring [DEPTH];

    // Completion queue, read at the tail
    done_t cmpl_q [DEPTH];
    logic  cmpl_last [DEPTH];

    logic [N_INFLIGHT_BITS-1:0] head_q;
    logic [N_INFLIGHT_BITS-1:0] tail_q;
    logic [N_INFLIGHT_BITS:0]   cnt_q;

    assign head  = head_q;
    assign tail  = tail_q;
    assign empty = (cnt_q == '0);
    assign full  = (cnt_q == (N_INFLIGHT_BITS+1)'(DEPTH));

    // Completion leaves with the dma_done that retires it
    assign m_done_valid = dma_done && cmpl_last[tail_q];
    assign m_done       = cmpl_q[tail_q];

    always_ff @(posedge aclk) begin
        if (push) begin
            ring[head_q]      <= push_entry;
            cmpl_q[head_q]    <= '{pid: push_entry.pid, dest: push_entry.dest};
            cmpl_last[head_q] <= push_entry.last;
        end
        rd_entry <= ring[rd_ptr];
    end

    // ------------------------------------------------
    // Pointers and occupancy
    // ------------------------------------------------
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            head_q <= '0;
            tail_q <= '0;
            cnt_q  <= '0;
        end else begin
            if (push) begin
                head_q <= head_q + 1'b1;
            end
            if (dma_done) begin
                tail_q <= tail_q + 1'b1;
            end
            case ({push, dma_done})
                2'b10:   cnt_q <= cnt_q + 1'b1;
                2'b01:   cnt_q <= cnt_q - 1'b1;
                default: cnt_q <= cnt_q;
            endcase
        end
    end

endmodule

// ==== inflight/invldt_scan.sv ====
// ------------------------------------------------
// Walks the in-flight ring for one invalidation and
// reports whether any outstanding piece overlaps it
// ------------------------------------------------
module invldt_scan
    import xlate_pkg::*;
#(
    parameter int N_INFLIGHT_BITS = 3
) (
    input  logic                       aclk,
    input  logic                       aresetn,
    input  logic                       scan_start,
    input  inv_t                       scan_inv,
    output logic                       scan_done,
    output logic                       scan_conflict,
    output logic [N_INFLIGHT_BITS-1:0] rd_ptr,
    input  entry_t                     rd_entry,
    input  logic [N_INFLIGHT_BITS-1:0] head,
    input  logic [N_INFLIGHT_BITS-1:0] tail,
    input  logic                       empty
);

    typedef enum logic [1:0] {SC_IDLE, SC_READ, SC_CMP} scan_state_t;
    typedef logic [VADDR_BITS:0] vsum_t;

    scan_state_t state_q;
    logic [N_INFLIGHT_BITS-1:0] ptr_q;
    inv_t inv_q;
    logic hit_q;
    logic done_q;

    vsum_t inv_end;
    vsum_t ent_end;
    logic  match;

    assign rd_ptr        = ptr_q;
    assign scan_done     = done_q;
    assign scan_conflict = hit_q;

    // Half-open byte ranges with one extra bit against wrap
    assign inv_end = vsum_t'(inv_q.vaddr) + vsum_t'(inv_q.len);
    assign ent_end = vsum_t'(rd_entry.vaddr) + vsum_t'(rd_entry.len);
    assign match   = (rd_entry.hpid == inv_q.hpid) &&
                     (vsum_t'(inv_q.vaddr) < ent_end) &&
                     (vsum_t'(rd_entry.vaddr) < inv_end);

    always_ff @(posedge aclk) begin
        if (scan_start) begin
            inv_q <= scan_inv;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state_q <= SC_IDLE;
            ptr_q   <= '0;
            hit_q   <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                SC_IDLE: begin
                    if (scan_start) begin
                        hit_q <= 1'b0;
                        ptr_q <= tail;
                        // Nothing outstanding so the scan is clean
                        if (empty) begin
                            done_q <= 1'b1;
                        end else begin
                            state_q <= SC_READ;
                        end
                    end
                end
                // rd_entry follows rd_ptr by one cycle
                SC_READ: state_q <= SC_CMP;
                SC_CMP: begin
                    hit_q <= hit_q || match;
                    ptr_q <= ptr_q + 1'b1;
                    if (ptr_q + 1'b1 == head) begin
                        done_q  <= 1'b1;
                        state_q <= SC_IDLE;
                    end else begin
                        state_q <= SC_READ;
                    end
                end
                default: state_q <= SC_IDLE;
            endcase
        end
    end

endmodule

// ==== xlate/xlate_fsm.sv ====
// ------------------------------------------------
// Request FSM: TLB lookup, split at page ends, DMA
// issue, page-fault reporting and invalidation entry
// ------------------------------------------------
module xlate_fsm
    import xlate_pkg::*;
#(
    parameter int PG_BITS = 21
) (
    input  logic     aclk,
    input  logic     aresetn,
    input  logic     s_req_valid,
    output logic     s_req_ready,
    input  req_t     s_req,
    output logic     tlb_lup_valid,
    output tlb_lup_t tlb_lup,
    input  tlb_rsp_t tlb_rsp,
    output logic     dma_valid,
    input  logic     dma_ready,
    output dma_req_t dma_req,
    output logic     m_pfault_valid,
    input  logic     m_pfault_ready,
    output pfault_t  m_pfault,
    input  logic     s_pfault_valid,
    output logic     s_pfault_ready,
    input  logic     s_pfault_retry,
    input  logic     s_invldt_valid,
    output logic     s_invldt_ready,
    input  inv_t     s_invldt,
    output logic     m_invldt_valid,
    input  logic     m_invldt_ready,
    output hpid_t    m_invldt,
    output logic     push,
    output entry_t   push_entry,
    input  logic     full,
    output logic     scan_start,
    output inv_t     scan_inv,
    input  logic     scan_done,
    input  logic     scan_conflict
);

    localparam len_t PG_SIZE = len_t'(1) << PG_BITS;

    fsm_state_t state_q, state_d;

    // Current request, advanced piece by piece
    vaddr_t vaddr_q;
    len_t   len_q;
    pid_t   pid_q;
    dest_t  dest_q;
    logic   last_q;

    // Lookup result and current piece
    paddr_t ppn_q;
    hpid_t  hpid_q;
    len_t   room_q;
    vaddr_t pvaddr_q;
    paddr_t paddr_q;
    len_t   plen_q;
    logic   plast_q;

    pfault_t pf_q;
    inv_t    inv_q;
    logic    scan_start_q;
    logic    inv_clean_q;
    logic    ret_miss_q;

    logic take_inv;
    logic send_fire;
    len_t plen;

    assign s_invldt_ready = (state_q == ST_IDLE) || (state_q == ST_MISS_IDLE);
    assign take_inv       = s_invldt_valid && s_invldt_ready;
    assign s_req_ready    = (state_q == ST_IDLE) && !s_invldt_valid;
    assign s_pfault_ready = (state_q == ST_MISS_IDLE) && !s_invldt_valid;

    // Only fire when the ring has room
    assign send_fire = (state_q == ST_SEND) && dma_ready && !full;
    assign plen      = (len_q < room_q) ? len_q : room_q;

    assign tlb_lup_valid = (state_q == ST_LUP);
    assign tlb_lup       = '{vaddr: vaddr_q, pid: pid_q};

    assign dma_valid  = send_fire;
    assign dma_req    = '{paddr: paddr_q, len: plen_q, last: plast_q};
    assign push       = send_fire;
    assign push_entry = '{vaddr: pvaddr_q, len: plen_q, hpid: hpid_q, pid: pid_q,
                          dest: dest_q, last: plast_q};

    assign m_pfault_valid = (state_q == ST_MISS_SEND);
    assign m_pfault       = pf_q;
    assign m_invldt_valid = (state_q == ST_INV_WAIT) && inv_clean_q && inv_q.last;
    assign m_invldt       = inv_q.hpid;
    assign scan_start     = scan_start_q;
    assign scan_inv       = inv_q;

    // ------------------------------------------------
    // Next state
    // ------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (take_inv) begin
                    state_d = ST_INV_WAIT;
                end else if (s_req_valid && s_req.len != '0) begin
                    state_d = ST_LUP;
                end
            end
            ST_LUP:    state_d = ST_WAIT_1;
            ST_WAIT_1: state_d = ST_WAIT_2;
            ST_WAIT_2: state_d = ST_CHECK;
            ST_CHECK:  state_d = tlb_rsp.hit ? ST_LATCH : ST_MISS_SEND;
            ST_LATCH:  state_d = ST_CALC;
            ST_CALC:   state_d = ST_SEND;
            ST_SEND: begin
                // len_q already holds what is left after this piece
                if (send_fire) begin
                    state_d = (len_q != '0) ? ST_LUP : ST_IDLE;
                end
            end
            ST_MISS_SEND: begin
                if (m_pfault_ready) begin
                    state_d = ST_MISS_IDLE;
                end
            end
            ST_MISS_IDLE: begin
                if (take_inv) begin
                    state_d = ST_INV_WAIT;
                end else if (s_pfault_valid) begin
                    state_d = s_pfault_retry ? ST_LUP : ST_IDLE;
                end
            end
            ST_INV_WAIT: begin
                if (inv_clean_q && (!inv_q.last || m_invldt_ready)) begin
                    state_d = ret_miss_q ? ST_MISS_IDLE : ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state_q      <= ST_IDLE;
            scan_start_q <= 1'b0;
            inv_clean_q  <= 1'b0;
            ret_miss_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            // Rescan until no piece overlaps
            scan_start_q <= take_inv ||
                            ((state_q == ST_INV_WAIT) && scan_done && scan_conflict);
            if (take_inv) begin
                inv_clean_q <= 1'b0;
                ret_miss_q  <= (state_q == ST_MISS_IDLE);
            end else if ((state_q == ST_INV_WAIT) && scan_done && !scan_conflict) begin
                inv_clean_q <= 1'b1;
            end
        end
    end

    // ------------------------------------------------
    // Request and piece datapath
    // ------------------------------------------------
    always_ff @(posedge aclk) begin
        if (take_inv) begin
            inv_q <= s_invldt;
        end
        if (s_req_valid && s_req_ready) begin
            vaddr_q <= s_req.vaddr;
            len_q   <= s_req.len;
            pid_q   <= s_req.pid;
            dest_q  <= s_req.dest;
            last_q  <= s_req.last;
        end
        case (state_q)
            ST_CHECK: begin
                ppn_q  <= tlb_rsp.ppn;
                hpid_q <= tlb_rsp.hpid;
                pf_q   <= '{vaddr: vaddr_q, len: len_q, pid: pid_q};
            end
            ST_LATCH: begin
                room_q <= PG_SIZE - len_t'(vaddr_q[PG_BITS-1:0]);
            end
            ST_CALC: begin
                paddr_q  <= {ppn_q[PADDR_BITS-PG_BITS-1:0], vaddr_q[PG_BITS-1:0]};
                plen_q   <= plen;
                pvaddr_q <= vaddr_q;
                plast_q  <= last_q && (plen == len_q);
                vaddr_q  <= vaddr_q + vaddr_t'(plen);
                len_q    <= len_q - plen;
            end
            default: ;
        endcase
    end

endmodule

// ==== src/xlate_top.sv ====
// ------------------------------------------------
// Host address translation controller top level.
// Joins the request FSM, the in-flight ring and the
// invalidation scanner; page size set by PG_BITS
// ------------------------------------------------
module xlate_top
    import xlate_pkg::*;
#(
    parameter int PG_BITS         = 21,
    parameter int N_INFLIGHT_BITS = 3
) (
    input  logic     aclk,
    input  logic     aresetn,
    // Requests
    input  logic     s_req_valid,
    output logic     s_req_ready,
    input  req_t     s_req,
    // External TLB
    output logic     tlb_lup_valid,
    output tlb_lup_t tlb_lup,
    input  tlb_rsp_t tlb_rsp,
    // Host DMA
    output logic     dma_valid,
    input  logic     dma_ready,
    output dma_req_t dma_req,
    input  logic     dma_done,
    output logic     m_done_valid,
    output done_t    m_done,
    // Page faults
    output logic     m_pfault_valid,
    input  logic     m_pfault_ready,
    output pfault_t  m_pfault,
    input  logic     s_pfault_valid,
    output logic     s_pfault_ready,
    input  logic     s_pfault_retry,
    // Invalidations
    input  logic     s_invldt_valid,
    output logic     s_invldt_ready,
    input  inv_t     s_invldt,
    output logic     m_invldt_valid,
    input  logic     m_invldt_ready,
    output hpid_t    m_invldt
);

    // Ring push side
    logic   push;
    entry_t push_entry;
    logic   full;

    // Ring scan side
    logic [N_INFLIGHT_BITS-1:0] rd_ptr;
    logic [N_INFLIGHT_BITS-1:0] head;
    logic [N_INFLIGHT_BITS-1:0] tail;
    entry_t rd_entry;
    logic   empty;

    logic scan_start;
    inv_t scan_inv;
    logic scan_done;
    logic scan_conflict;

    xlate_fsm #(.PG_BITS(PG_BITS)) u_fsm (.*);

    inflight_tracker #(.N_INFLIGHT_BITS(N_INFLIGHT_BITS)) u_tracker (.*);

    invldt_scan #(.N_INFLIGHT_BITS(N_INFLIGHT_BITS)) u_scan (.*);

endmodule

// ==== bench/xlate_asserts.sv ====
// ------------------------------------------------
// Protocol checks on the controller ports, bound
// into the top level by the testbench
// ------------------------------------------------
module xlate_asserts
    import xlate_pkg::*;
(
    input logic    aclk,
    input logic    aresetn,
    input logic    tlb_lup_valid,
    input logic    dma_valid,
    input logic    dma_ready,
    input logic    dma_done,
    input logic    m_done_valid,
    input logic    m_pfault_valid,
    input logic    m_pfault_ready,
    input pfault_t m_pfault,
    input logic    m_invldt_valid,
    input logic    m_invldt_ready,
    input hpid_t   m_invldt
);

    // A piece moves only while the DMA side is ready
    assert property (@(posedge aclk) disable iff (!aresetn) dma_valid |-> dma_ready)
        else $error("dma_valid high while dma_ready is low");

    assert property (@(posedge aclk) disable iff (!aresetn) tlb_lup_valid |=> !tlb_lup_valid)
        else $error("TLB lookup strobe longer than one cycle");

    // Completion rides on the retiring dma_done
    assert property (@(posedge aclk) disable iff (!aresetn) m_done_valid |-> dma_done)
        else $error("m_done_valid without dma_done");

    assert property (@(posedge aclk) disable iff (!aresetn)
        m_pfault_valid && !m_pfault_ready |=> m_pfault_valid && $stable(m_pfault))
        else $error("page fault report dropped or changed before ready");

    assert property (@(posedge aclk) disable iff (!aresetn)
        m_invldt_valid && !m_invldt_ready |=> m_invldt_valid && $stable(m_invldt))
        else $error("invalidation ack dropped or changed before ready");

    assert property (@(posedge aclk) !aresetn |=>
        !(dma_valid || tlb_lup_valid || m_done_valid || m_pfault_valid || m_invldt_valid))
        else $error("output valid high right after reset");

endmodule

// ==== bench/xlate_tb.sv ====
// ------------------------------------------------
// Testbench for the translation controller: TLB and
// DMA responder models, test sequence and report
// ------------------------------------------------
module xlate_tb
    import xlate_pkg::*;
;

    localparam int PG_BITS         = 21;
    localparam int N_INFLIGHT_BITS = 3;
    localparam int DEPTH           = 1 << N_INFLIGHT_BITS;
    localparam len_t PG_SIZE       = len_t'(1) << PG_BITS;
    localparam logic [31:0] SEED   = 32'h43fb_56e2;
    // Per-test budget covers about 13 pieces plus hold windows
    localparam int TEST_BUDGET     = 640;
    localparam int TIMEOUT_CYCLES  = 6 * TEST_BUDGET + 160;
    // TLB table contents
    localparam int    PPN_BASE = 'h40;
    localparam hpid_t TLB_HPID = 16'h00a5;
    localparam vaddr_t VA1 = (vaddr_t'(2) << PG_BITS) + 'h3_4000;
    localparam vaddr_t VA2 = (vaddr_t'(4) << PG_BITS) + 'h1f_0000;
    localparam vaddr_t VA3 = (vaddr_t'(9) << PG_BITS) + 'h800;
    localparam vaddr_t VA4 = (vaddr_t'(11) << PG_BITS) + 'h40;
    localparam vaddr_t VA5 = (vaddr_t'(3) << PG_BITS) + 'h200;
    localparam vaddr_t VA6 = (vaddr_t'(20) << PG_BITS) + 'h1000;

    logic aclk = 1'b0;
    logic aresetn, s_req_valid, s_req_ready, tlb_lup_valid;
    req_t s_req;
    tlb_lup_t tlb_lup;
    tlb_rsp_t tlb_rsp = '0;
    logic dma_valid, m_done_valid, m_pfault_valid, m_pfault_ready;
    logic dma_ready = 1'b0;
    logic dma_done  = 1'b0;
    dma_req_t dma_req;
    done_t m_done;
    pfault_t m_pfault;
    logic s_pfault_valid, s_pfault_ready, s_pfault_retry;
    logic s_invldt_valid, s_invldt_ready, m_invldt_valid, m_invldt_ready;
    inv_t s_invldt;
    hpid_t m_invldt;

    // Bench state shared by the models and the sequence
    paddr_t ppn_tab [longint];
    dma_req_t pieces [$];
    done_t dones [$];
    pfault_t faults [$];
    hpid_t acks [$];
    logic lup_v [2] = '{1'b0, 1'b0};
    vaddr_t lup_va [2];
    pid_t req_pid = '0;
    logic [31:0] rnd = SEED;
    int cycle = 0;
    int outstanding = 0;
    int done_wait = 0;
    int retire_cycle = 0;
    int ack_cycle = 0;
    logic hold_done = 1'b0;
    int errors = 0;
    int errs_at_start = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int bp, bd, bf, ba;

    xlate_top #(.PG_BITS(PG_BITS), .N_INFLIGHT_BITS(N_INFLIGHT_BITS)) DUT (.*);

    bind xlate_top xlate_asserts u_asserts (.*);

    always #4 aclk = ~aclk;

    function automatic logic [31:0] next_random(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic tlb_rsp_t tlb_answer(input logic v, input vaddr_t va);
        longint pg;
        tlb_rsp_t r;
        pg = longint'(va >> PG_BITS);
        r  = '0;
        if (v && ppn_tab.exists(pg)) begin
            r.hit  = 1'b1;
            r.ppn  = ppn_tab[pg];
            r.hpid = TLB_HPID;
        end
        return r;
    endfunction

    // TLB answers in the third cycle after the strobe
    always @(posedge aclk) begin
        logic   v;
        vaddr_t va;
        v         = lup_v[1];
        va        = lup_va[1];
        lup_v[1]  = lup_v[0];
        lup_va[1] = lup_va[0];
        lup_v[0]  = tlb_lup_valid;
        lup_va[0] = tlb_lup.vaddr;
        if (tlb_lup_valid) begin
            compare_value("lookup pid", tlb_lup.pid, req_pid);
        end
        #1;
        tlb_rsp = tlb_answer(v, va);
    end

    // ------------------------------------------------
    // DMA responder and port monitor
    // ------------------------------------------------
    always @(posedge aclk) begin
        logic ready_next;
        logic done_next;
        if (aresetn) begin
            if (dma_valid) begin
                pieces.push_back(dma_req);
                outstanding++;
            end
            if (dma_done) begin
                outstanding--;
                retire_cycle = cycle;
            end
            if (m_done_valid) dones.push_back(m_done);
            if (m_pfault_valid && m_pfault_ready) faults.push_back(m_pfault);
            if (m_invldt_valid && m_invldt_ready) begin
                acks.push_back(m_invldt);
                ack_cycle = cycle;
            end
            assert (outstanding <= DEPTH) else begin
                $display("Fail at %0t: %0d pieces outstanding, ring holds %0d",
                         $time, outstanding, DEPTH);
                errors++;
            end
        end
        rnd        = next_random(rnd);
        ready_next = (rnd[1:0] != 2'b00);
        done_next  = 1'b0;
        if (!hold_done && outstanding > 0 && done_wait == 0) begin
            done_next = 1'b1;
            done_wait = int'(rnd[4:3]);
        end else if (done_wait > 0) begin
            done_wait--;
        end
        #1;
        dma_ready = ready_next;
        dma_done  = done_next;
    end

    always @(posedge aclk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic step();
        @(posedge aclk);
        #1;
    endtask

    task automatic compare_value(input string what, input longint got, input longint exp);
        assert (got == exp) else begin
            $display("Fail at %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic fill_page(input longint pg);
        ppn_tab[pg] = paddr_t'(PPN_BASE + 7 * pg);
    endtask

    task automatic send_req(input vaddr_t va, input len_t len, input pid_t pid, input dest_t dest);
        req_pid     = pid;
        s_req_valid = 1'b1;
        s_req       = '{vaddr: va, len: len, pid: pid, dest: dest, last: 1'b1};
        @(posedge aclk);
        while (!s_req_ready) @(posedge aclk);
        #1;
        s_req_valid = 1'b0;
    endtask

    task automatic send_inv(input vaddr_t va, input len_t len, input hpid_t hpid);
        s_invldt_valid = 1'b1;
        s_invldt       = '{vaddr: va, len: len, hpid: hpid, last: 1'b1};
        @(posedge aclk);
        while (!s_invldt_ready) @(posedge aclk);
        #1;
        s_invldt_valid = 1'b0;
    endtask

    // Fault report is held a few cycles before it is taken
    task automatic take_fault();
        while (!m_pfault_valid) step();
        repeat (3) step();
        m_pfault_ready = 1'b1;
        while (faults.size() < bf + 1) step();
        m_pfault_ready = 1'b0;
    endtask

    // Acknowledge is held a few cycles before it is taken
    task automatic take_ack();
        while (!m_invldt_valid) step();
        repeat (3) step();
        m_invldt_ready = 1'b1;
        while (acks.size() < ba + 1) step();
    endtask

    task automatic answer_fault(input logic retry);
        s_pfault_valid = 1'b1;
        s_pfault_retry = retry;
        @(posedge aclk);
        while (!s_pfault_ready) @(posedge aclk);
        #1;
        s_pfault_valid = 1'b0;
    endtask

    // Expected pieces from the page split rule
    task automatic check_pieces(input int first, input vaddr_t va, input len_t len);
        vaddr_t cur;
        len_t   left;
        len_t   room;
        len_t   plen;
        longint sum;
        longint exp_paddr;
        int     idx;
        cur  = va;
        left = len;
        idx  = first;
        sum  = 0;
        while (left != '0) begin
            room      = PG_SIZE - len_t'(cur[PG_BITS-1:0]);
            plen      = (left < room) ? left : room;
            exp_paddr = (longint'(ppn_tab[longint'(cur >> PG_BITS)]) << PG_BITS) |
                        longint'(cur[PG_BITS-1:0]);
            if (idx < pieces.size()) begin
                compare_value("piece paddr", pieces[idx].paddr, exp_paddr);
                compare_value("piece len", pieces[idx].len, plen);
                compare_value("piece last", pieces[idx].last, plen == left);
                sum += pieces[idx].len;
            end
            cur  = cur + vaddr_t'(plen);
            left = left - plen;
            idx++;
        end
        compare_value("piece count", pieces.size() - first, idx - first);
        compare_value("piece length sum", sum, len);
    endtask

    task automatic check_done(input int idx, input pid_t pid, input dest_t dest);
        compare_value("completion count", dones.size(), idx + 1);
        compare_value("completion pid", dones[idx].pid, pid);
        compare_value("completion dest", dones[idx].dest, dest);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == errs_at_start) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - errs_at_start);
        end
        errs_at_start = errors;
    endtask

    task automatic mark();
        bp = pieces.size();
        bd = dones.size();
        bf = faults.size();
        ba = acks.size();
    endtask

    // ------------------------------------------------
    // Test sequence
    // ------------------------------------------------
    initial begin
        aresetn        = 1'b0;
        s_req_valid    = 1'b0;
        s_req          = '0;
        m_pfault_ready = 1'b0;
        s_pfault_valid = 1'b0;
        s_pfault_retry = 1'b0;
        s_invldt_valid = 1'b0;
        s_invldt       = '0;
        m_invldt_ready = 1'b0;
        for (longint p = 2; p <= 6; p++) fill_page(p);
        for (longint p = 20; p <= 32; p++) fill_page(p);
        repeat (4) @(posedge aclk);
        #1;
        aresetn        = 1'b1;
        m_invldt_ready = 1'b1;
        step();

        mark();
        send_req(VA1, 28'h800, 6'd5, 4'd3);
        while (dones.size() < bd + 1) step();
        check_pieces(bp, VA1, 28'h800);
        check_done(bd, 6'd5, 4'd3);
        end_test("single-page hit");

        mark();
        send_req(VA2, 28'h21_8000, 6'd7, 4'd2);
        while (dones.size() < bd + 1) step();
        check_pieces(bp, VA2, 28'h21_8000);
        check_done(bd, 6'd7, 4'd2);
        end_test("page-crossing split");

        mark();
        send_req(VA3, 28'h400, 6'd12, 4'd6);
        take_fault();
        compare_value("fault vaddr", faults[bf].vaddr, VA3);
        compare_value("fault len", faults[bf].len, 28'h400);
        compare_value("fault pid", faults[bf].pid, 6'd12);
        fill_page(9);
        answer_fault(1'b1);
        while (dones.size() < bd + 1) step();
        check_pieces(bp, VA3, 28'h400);
        check_done(bd, 6'd12, 4'd6);
        mark();
        send_req(VA4, 28'h100, 6'd13, 4'd1);
        take_fault();
        answer_fault(1'b0);
        while (!s_req_ready) step();
        compare_value("pieces after drop", pieces.size(), bp);
        end_test("miss with retry and drop");

        mark();
        m_invldt_ready = 1'b0;
        send_inv(VA1, 28'h1000, 16'h1234);
        take_ack();
        compare_value("ack hpid", acks[ba], 16'h1234);
        end_test("invalidation on empty ring");

        mark();
        hold_done = 1'b1;
        send_req(VA5, 28'h100, 6'd9, 4'd1);
        while (pieces.size() < bp + 1) step();
        send_inv(VA5 + 'h80, 28'h40, TLB_HPID);
        repeat (40) step();
        compare_value("acks while piece held", acks.size(), ba);
        hold_done = 1'b0;
        while (acks.size() < ba + 1 || dones.size() < bd + 1) step();
        compare_value("ack after retire", ack_cycle > retire_cycle, 1);
        compare_value("ack hpid", acks[ba], TLB_HPID);
        end_test("invalidation with piece in flight");

        mark();
        hold_done = 1'b1;
        send_req(VA6, 28'h180_0000, 6'd33, 4'd9);
        while (outstanding < DEPTH) step();
        repeat (20) step();
        compare_value("outstanding with ring full", outstanding, DEPTH);
        hold_done = 1'b0;
        while (dones.size() < bd + 1) step();
        check_pieces(bp, VA6, 28'h180_0000);
        check_done(bd, 6'd33, 4'd9);
        end_test("back-pressure and full ring");

        $display("%0d tests, %0d passed, %0d failed, %0d check errors",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
common/xlate_pkg.sv
inflight/inflight_tracker.sv
inflight/invldt_scan.sv
xlate/xlate_fsm.sv
src/xlate_top.sv
bench/xlate_asserts.sv
bench/xlate_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the translation controller testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module xlate_tb -f verilog.f \
    -o xlate_sim > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/xlate_sim > sim.log 2>&1
grep -q "TEST FAIL" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "TEST PASS" sim.log && echo "Simulation passed" || { echo "No pass line in sim.log"; exit 1; }
